// File: verilog/alu_pkg.sv
package alu_pkg;

	// Datapath widths
	localparam int WORD_W = 32;
	localparam int RESULT_W = 2 * WORD_W;
	localparam int IMM_W = 19;
	localparam int SEQ_W = 8;
	localparam int MD_STEP_W = $clog2(WORD_W);

	// Command queue geometry with a power-of-two depth
	localparam int CMD_FIFO_DEPTH = 4;
	localparam int FIFO_PTR_W = $clog2(CMD_FIFO_DEPTH);
	localparam int FIFO_CNT_W = $clog2(CMD_FIFO_DEPTH + 1);

	// Opcode map of the teaching processor
	// Divide moved to the free code 11011 since its old code 01000 collides with rotate left
	typedef enum logic [4:0] {
		op_load   = 5'b00000,
		op_loadi  = 5'b00001,
		op_store  = 5'b00010,
		op_add    = 5'b00011,
		op_sub    = 5'b00100,
		op_shr    = 5'b00101,
		op_shl    = 5'b00110,
		op_ror    = 5'b00111,
		op_rol    = 5'b01000,
		op_and    = 5'b01001,
		op_or     = 5'b01010,
		op_addi   = 5'b01011,
		op_andi   = 5'b01100,
		op_ori    = 5'b01101,
		op_mul    = 5'b01111,
		op_neg    = 5'b10000,
		op_not    = 5'b10001,
		op_branch = 5'b10010,
		op_jr     = 5'b10011,
		op_jal    = 5'b10100,
		op_in     = 5'b10101,
		op_out    = 5'b10110,
		op_mfhi   = 5'b10111,
		op_mflo   = 5'b11000,
		op_nop    = 5'b11001,
		op_halt   = 5'b11010,
		op_div    = 5'b11011
	} alu_op_e;

	// Raw command from the source
	typedef struct packed {
		alu_op_e opcode;
		logic [WORD_W-1:0] y;
		logic [WORD_W-1:0] b;
		logic [IMM_W-1:0] imm;
	} alu_issue_t;

	// Decoded command with B already resolved
	typedef struct packed {
		alu_op_e opcode;
		logic [WORD_W-1:0] y;
		logic [WORD_W-1:0] b;
		logic [SEQ_W-1:0] seq;
	} alu_cmd_t;

	typedef struct packed {
		logic [SEQ_W-1:0] seq;
		alu_op_e opcode;
		logic [RESULT_W-1:0] c;
	} alu_result_t;

endpackage

// File: verilog/shift_rotate.sv
`timescale 1ns/1ps

module shift_rotate (
	input logic [alu_pkg::WORD_W-1:0] value,
	input logic [4:0] amount,
	input alu_pkg::alu_op_e opcode,
	output logic [alu_pkg::WORD_W-1:0] out_value
);
	logic is_left;
	logic is_rotate;
	logic [alu_pkg::WORD_W-1:0] stage [6];

	assign is_left = (opcode == alu_pkg::op_shl) || (opcode == alu_pkg::op_rol);
	assign is_rotate = (opcode == alu_pkg::op_ror) || (opcode == alu_pkg::op_rol);

	// Left kinds run through the right shifter on bit-reversed data
	assign stage[0] = is_left ? {<<{value}} : value;

	genvar i;
	for (i = 0; i < 5; i++) begin : g_stage
		logic [(1 << i)-1:0] fill;

		// Rotate feeds the dropped bits back in at the top
		assign fill = is_rotate ? stage[i][(1 << i)-1:0] : {(1 << i){1'b0}};
		assign stage[i+1] = amount[i] ? {fill, stage[i][alu_pkg::WORD_W-1:(1 << i)]} : stage[i];
	end

	assign out_value = is_left ? {<<{stage[5]}} : stage[5];

endmodule

// File: verilog/mul_div_seq.sv
`timescale 1ns/1ps

module mul_div_seq (
	input logic clk,
	input logic rst,
	input logic start,
	input logic is_div,
	input logic [alu_pkg::WORD_W-1:0] y,
	input logic [alu_pkg::WORD_W-1:0] b,
	output logic done,
	output logic [alu_pkg::WORD_W-1:0] hi,
	output logic [alu_pkg::WORD_W-1:0] lo
);
	logic running;
	logic [alu_pkg::MD_STEP_W-1:0] step;
	logic div_mode;
	logic neg_main;
	logic neg_rem;
	logic div_zero;
	logic [alu_pkg::WORD_W-1:0] abs_y;
	logic [alu_pkg::WORD_W-1:0] abs_b;
	// Multiplicand or divisor magnitude
	logic [alu_pkg::WORD_W-1:0] opnd;
	// Partial product high half, or partial remainder
	logic [alu_pkg::WORD_W:0] acc_hi;
	// Multiplier bits, or dividend bits turning into quotient bits
	logic [alu_pkg::WORD_W-1:0] acc_lo;
	logic [alu_pkg::WORD_W:0] add_sum;
	logic [alu_pkg::WORD_W:0] shifted;
	logic [alu_pkg::WORD_W:0] diff;
	logic fits;
	logic [alu_pkg::RESULT_W-1:0] prod_mag;
	logic [alu_pkg::RESULT_W-1:0] prod;
	logic [alu_pkg::WORD_W-1:0] quot;
	logic [alu_pkg::WORD_W-1:0] rem;

	assign abs_y = y[alu_pkg::WORD_W-1] ? -y : y;
	assign abs_b = b[alu_pkg::WORD_W-1] ? -b : b;

	// Shift-add step
	assign add_sum = acc_hi + (acc_lo[0] ? {1'b0, opnd} : '0);

	// Restoring divide step
	assign shifted = {acc_hi[alu_pkg::WORD_W-1:0], acc_lo[alu_pkg::WORD_W-1]};
	assign diff = shifted - {1'b0, opnd};
	assign fits = shifted >= {1'b0, opnd};

	always_ff @(posedge clk) begin
		if (rst) begin
			running <= 1'b0;
			done <= 1'b0;
			step <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				running <= 1'b1;
				step <= '0;
			end else if (running) begin
				step <= step + 1'b1;
				if (step == '1) begin
					running <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			div_mode <= is_div;
			opnd <= is_div ? abs_b : abs_y;
			acc_lo <= is_div ? abs_y : abs_b;
			acc_hi <= '0;
			neg_main <= y[alu_pkg::WORD_W-1] ^ b[alu_pkg::WORD_W-1];
			neg_rem <= y[alu_pkg::WORD_W-1];
			div_zero <= is_div && (b == '0);
		end else if (running) begin
			if (div_mode) begin
				acc_hi <= fits ? diff : shifted;
				acc_lo <= {acc_lo[alu_pkg::WORD_W-2:0], fits};
			end else begin
				acc_hi <= {1'b0, add_sum[alu_pkg::WORD_W:1]};
				acc_lo <= {add_sum[0], acc_lo[alu_pkg::WORD_W-1:1]};
			end
		end
	end

	// Sign fixup on the unsigned magnitudes
	assign prod_mag = {acc_hi[alu_pkg::WORD_W-1:0], acc_lo};
	assign prod = neg_main ? -prod_mag : prod_mag;
	assign quot = div_zero ? '1 : (neg_main ? -acc_lo : acc_lo);
	// Remainder follows the dividend sign
	assign rem = neg_rem ? -acc_hi[alu_pkg::WORD_W-1:0] : acc_hi[alu_pkg::WORD_W-1:0];

	assign hi = div_mode ? rem : prod[alu_pkg::RESULT_W-1:alu_pkg::WORD_W];
	assign lo = div_mode ? quot : prod[alu_pkg::WORD_W-1:0];

	a_no_start_running: assert property (@(posedge clk) disable iff (rst)
		start |-> !running)
		else $error("mul/div start while an operation is running");

endmodule

// File: verilog/cmd_decode.sv
`timescale 1ns/1ps

module cmd_decode (
	input logic clk,
	input logic rst,
	input logic issue,
	input alu_pkg::alu_issue_t issue_cmd,
	input logic busy,
	output logic push,
	output alu_pkg::alu_cmd_t push_cmd,
	output logic reject
);
	logic legal;
	logic use_imm;
	logic accept;
	logic [alu_pkg::WORD_W-1:0] imm_ext;
	logic [alu_pkg::WORD_W-1:0] b_sel;
	logic [alu_pkg::SEQ_W-1:0] seq;

	// Opcodes owned by this unit
	always_comb begin
		legal = 1'b0;
		use_imm = 1'b0;
		case (issue_cmd.opcode)
			alu_pkg::op_load, alu_pkg::op_loadi, alu_pkg::op_store,
			alu_pkg::op_addi, alu_pkg::op_andi, alu_pkg::op_ori: begin
				legal = 1'b1;
				use_imm = 1'b1;
			end
			alu_pkg::op_add, alu_pkg::op_sub, alu_pkg::op_and, alu_pkg::op_or,
			alu_pkg::op_neg, alu_pkg::op_not, alu_pkg::op_shr, alu_pkg::op_shl,
			alu_pkg::op_ror, alu_pkg::op_rol, alu_pkg::op_mul, alu_pkg::op_div,
			alu_pkg::op_mfhi, alu_pkg::op_mflo: begin
				legal = 1'b1;
			end
			default: begin
				legal = 1'b0;
			end
		endcase
	end

	assign imm_ext = {{(alu_pkg::WORD_W - alu_pkg::IMM_W){issue_cmd.imm[alu_pkg::IMM_W-1]}},
		issue_cmd.imm};
	assign b_sel = use_imm ? imm_ext : issue_cmd.b;

	// Busy is sampled on the issue edge itself
	assign accept = issue && legal && !busy;

	always_ff @(posedge clk) begin
		if (rst) begin
			push <= 1'b0;
			reject <= 1'b0;
			seq <= '0;
		end else begin
			push <= accept;
			reject <= issue && !accept;
			if (accept) begin
				seq <= seq + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			push_cmd.opcode <= issue_cmd.opcode;
			push_cmd.y <= issue_cmd.y;
			push_cmd.b <= b_sel;
			push_cmd.seq <= seq;
		end
	end

	a_push_reject_excl: assert property (@(posedge clk) disable iff (rst)
		!(push && reject))
		else $error("push and reject high together");

endmodule

// File: verilog/cmd_fifo.sv
`timescale 1ns/1ps

module cmd_fifo (
	input logic clk,
	input logic rst,
	input logic push,
	input alu_pkg::alu_cmd_t push_cmd,
	input logic pop,
	output alu_pkg::alu_cmd_t head,
	output logic not_empty,
	output logic busy
);
	alu_pkg::alu_cmd_t mem [alu_pkg::CMD_FIFO_DEPTH];
	logic [alu_pkg::FIFO_PTR_W-1:0] wr_ptr;
	logic [alu_pkg::FIFO_PTR_W-1:0] rd_ptr;
	logic [alu_pkg::FIFO_CNT_W-1:0] count;

	assign head = mem[rd_ptr];
	assign not_empty = count != '0;

	// One slot held back for the command already in the decoder register
	assign busy = count >= alu_pkg::FIFO_CNT_W'(alu_pkg::CMD_FIFO_DEPTH - 1);

	// Pointers wrap naturally at the depth
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_cmd;
		end
	end

	a_no_push_full: assert property (@(posedge clk) disable iff (rst)
		push |-> (count != alu_pkg::FIFO_CNT_W'(alu_pkg::CMD_FIFO_DEPTH)))
		else $error("push into a full command queue");

	a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
		pop |-> not_empty)
		else $error("pop from an empty command queue");

endmodule

// File: verilog/alu_exec.sv
`timescale 1ns/1ps

module alu_exec (
	input logic clk,
	input logic rst,
	input alu_pkg::alu_cmd_t head,
	input logic not_empty,
	output logic pop,
	output logic result_valid,
	output alu_pkg::alu_result_t result
);
	typedef enum logic [1:0] {
		st_idle,
		st_single,
		st_wait_md
	} exec_state_e;

	exec_state_e state;
	alu_pkg::alu_cmd_t cur;
	logic [alu_pkg::WORD_W-1:0] hi_reg;
	logic [alu_pkg::WORD_W-1:0] lo_reg;
	logic [alu_pkg::WORD_W-1:0] shift_out;
	logic [alu_pkg::WORD_W-1:0] single_c;
	logic [alu_pkg::RESULT_W-1:0] c_next;
	logic head_is_md;
	logic md_start;
	logic md_done;
	logic [alu_pkg::WORD_W-1:0] md_hi;
	logic [alu_pkg::WORD_W-1:0] md_lo;
	logic load_result;

	assign pop = (state == st_idle) && not_empty;
	assign head_is_md = (head.opcode == alu_pkg::op_mul) || (head.opcode == alu_pkg::op_div);

	shift_rotate u_shift (
		.value(cur.y),
		.amount(cur.b[4:0]),
		.opcode(cur.opcode),
		.out_value(shift_out)
	);

	mul_div_seq u_mul_div (
		.clk(clk),
		.rst(rst),
		.start(md_start),
		.is_div(cur.opcode == alu_pkg::op_div),
		.y(cur.y),
		.b(cur.b),
		.done(md_done),
		.hi(md_hi),
		.lo(md_lo)
	);

	// Single-cycle result select
	always_comb begin
		case (cur.opcode)
			alu_pkg::op_add, alu_pkg::op_addi, alu_pkg::op_load,
			alu_pkg::op_loadi, alu_pkg::op_store: single_c = cur.y + cur.b;
			alu_pkg::op_sub: single_c = cur.y - cur.b;
			alu_pkg::op_and, alu_pkg::op_andi: single_c = cur.y & cur.b;
			alu_pkg::op_or, alu_pkg::op_ori: single_c = cur.y | cur.b;
			alu_pkg::op_neg: single_c = -cur.b;
			alu_pkg::op_not: single_c = ~cur.b;
			alu_pkg::op_shr, alu_pkg::op_shl,
			alu_pkg::op_ror, alu_pkg::op_rol: single_c = shift_out;
			alu_pkg::op_mfhi: single_c = hi_reg;
			alu_pkg::op_mflo: single_c = lo_reg;
			default: single_c = '0;
		endcase
	end

	assign c_next = (state == st_wait_md) ? {md_hi, md_lo} : {{alu_pkg::WORD_W{1'b0}}, single_c};
	assign load_result = (state == st_single) || ((state == st_wait_md) && md_done);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			md_start <= 1'b0;
			result_valid <= 1'b0;
			hi_reg <= '0;
			lo_reg <= '0;
		end else begin
			md_start <= 1'b0;
			result_valid <= 1'b0;
			case (state)
				st_idle: begin
					if (pop) begin
						state <= head_is_md ? st_wait_md : st_single;
						md_start <= head_is_md;
					end
				end
				st_single: begin
					result_valid <= 1'b1;
					state <= st_idle;
				end
				st_wait_md: begin
					// HI and LO update together with the result
					if (md_done) begin
						hi_reg <= md_hi;
						lo_reg <= md_lo;
						result_valid <= 1'b1;
						state <= st_idle;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			cur <= head;
		end
		if (load_result) begin
			result.seq <= cur.seq;
			result.opcode <= cur.opcode;
			result.c <= c_next;
		end
	end

	// Pop only from idle, and each popped command ends in a result before the next pop
	a_pop_one_result: assert property (@(posedge clk) disable iff (rst)
		pop |=> (!pop until result_valid))
		else $error("pop before the previous command produced its result");

endmodule

// File: verilog/alu_top.sv
`timescale 1ns/1ps

module alu_top (
	input logic clk,
	input logic rst,
	input logic issue,
	input alu_pkg::alu_issue_t issue_cmd,
	output logic busy,
	output logic reject,
	output logic result_valid,
	output alu_pkg::alu_result_t result
);
	logic push;
	alu_pkg::alu_cmd_t push_cmd;
	logic pop;
	alu_pkg::alu_cmd_t head;
	logic not_empty;

	cmd_decode u_decode (
		.clk(clk),
		.rst(rst),
		.issue(issue),
		.issue_cmd(issue_cmd),
		.busy(busy),
		.push(push),
		.push_cmd(push_cmd),
		.reject(reject)
	);

	// Queue between decode and execute
	cmd_fifo u_fifo (
		.clk(clk),
		.rst(rst),
		.push(push),
		.push_cmd(push_cmd),
		.pop(pop),
		.head(head),
		.not_empty(not_empty),
		.busy(busy)
	);

	alu_exec u_exec (
		.clk(clk),
		.rst(rst),
		.head(head),
		.not_empty(not_empty),
		.pop(pop),
		.result_valid(result_valid),
		.result(result)
	);

endmodule

// File: sim/alu_checker.sv
`timescale 1ns/1ps

module alu_checker (
	input logic clk,
	input logic rst,
	input logic issue,
	input alu_pkg::alu_issue_t issue_cmd,
	input logic busy,
	input logic reject,
	input logic result_valid,
	input alu_pkg::alu_result_t result,
	input int test_id,
	input logic test_end,
	input logic all_done,
	output int pending,
	output int error_count
);
	alu_pkg::alu_result_t exp_q[$];
	alu_pkg::alu_result_t exp_item;
	logic [31:0] hi_model;
	logic [31:0] lo_model;
	logic [7:0] seq_model;
	logic [31:0] b_res;
	logic exp_reject;
	logic seen_issue;
	int checks;
	int test_checks;
	int test_errors;
	int tests_run;

	function automatic bit is_legal(input alu_pkg::alu_op_e op);
		case (op)
			alu_pkg::op_add, alu_pkg::op_sub, alu_pkg::op_and, alu_pkg::op_or,
			alu_pkg::op_neg, alu_pkg::op_not, alu_pkg::op_shr, alu_pkg::op_shl,
			alu_pkg::op_ror, alu_pkg::op_rol, alu_pkg::op_mul, alu_pkg::op_div,
			alu_pkg::op_mfhi, alu_pkg::op_mflo, alu_pkg::op_addi, alu_pkg::op_andi,
			alu_pkg::op_ori, alu_pkg::op_load, alu_pkg::op_loadi,
			alu_pkg::op_store: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic bit uses_imm(input alu_pkg::alu_op_e op);
		return op inside {alu_pkg::op_addi, alu_pkg::op_andi, alu_pkg::op_ori,
			alu_pkg::op_load, alu_pkg::op_loadi, alu_pkg::op_store};
	endfunction

	// Expected 64-bit c for one command
	function automatic logic [63:0] expected_c(input alu_pkg::alu_op_e op,
		input logic [31:0] y, input logic [31:0] b,
		input logic [31:0] hi, input logic [31:0] lo);
		logic [63:0] twice;
		logic [31:0] w;
		longint ys;
		longint bs;
		longint q;
		longint r;
		ys = {{32{y[31]}}, y};
		bs = {{32{b[31]}}, b};
		w = '0;
		case (op)
			alu_pkg::op_add, alu_pkg::op_addi, alu_pkg::op_load,
			alu_pkg::op_loadi, alu_pkg::op_store: w = y + b;
			alu_pkg::op_sub: w = y - b;
			alu_pkg::op_and, alu_pkg::op_andi: w = y & b;
			alu_pkg::op_or, alu_pkg::op_ori: w = y | b;
			alu_pkg::op_neg: w = -b;
			alu_pkg::op_not: w = ~b;
			alu_pkg::op_shr: w = y >> b[4:0];
			alu_pkg::op_shl: w = y << b[4:0];
			alu_pkg::op_ror: begin
				twice = {y, y} >> b[4:0];
				w = twice[31:0];
			end
			alu_pkg::op_rol: begin
				twice = {y, y} << b[4:0];
				w = twice[63:32];
			end
			alu_pkg::op_mfhi: w = hi;
			alu_pkg::op_mflo: w = lo;
			alu_pkg::op_mul: return ys * bs;
			alu_pkg::op_div: begin
				if (b == '0) begin
					return {y, 32'hffff_ffff};
				end
				// 64-bit math keeps min / -1 from overflowing
				q = ys / bs;
				r = ys % bs;
				return {r[31:0], q[31:0]};
			end
			default: w = '0;
		endcase
		return {32'h0, w};
	endfunction

	function automatic string test_name(input int id);
		case (id)
			1: return "quiet after reset";
			2: return "single-cycle ops";
			3: return "immediate forms";
			4: return "mul/div with HI and LO";
			5: return "back-to-back ordering";
			6: return "illegal and busy rejects";
			default: return "unnamed";
		endcase
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] want);
		checks++;
		test_checks++;
		if (got !== want) begin
			$display("[ERROR] %s got 0x%0h expected 0x%0h at %0t", name, got, want, $time);
			error_count++;
			test_errors++;
		end
	endtask

	task automatic report_problem(input string msg);
		$display("Problem at %0t: %s", $time, msg);
		error_count++;
		test_errors++;
	endtask

	initial begin
		pending = 0;
		error_count = 0;
		checks = 0;
		test_checks = 0;
		test_errors = 0;
		tests_run = 0;
	end

	always @(posedge clk) begin
		if (rst) begin
			exp_q.delete();
			hi_model = '0;
			lo_model = '0;
			seq_model = '0;
			exp_reject = 1'b0;
			seen_issue = 1'b0;
		end else begin
			if (!seen_issue && (busy || reject || result_valid)) begin
				report_problem("an output went high before the first issue");
			end

			// Outstanding commands sit in the decoder, the queue or the execution unit
			if (exp_q.size() >= alu_pkg::CMD_FIFO_DEPTH + 1 && !busy) begin
				report_problem("busy stayed low with the command queue nearly full");
			end
			if (exp_q.size() <= alu_pkg::CMD_FIFO_DEPTH - 2 && busy) begin
				report_problem("busy went high with the command queue nearly empty");
			end

			check_value("reject", reject, exp_reject);
			if (result_valid) begin
				if (exp_q.size() == 0) begin
					report_problem("result_valid pulsed with no command outstanding");
				end else begin
					exp_item = exp_q.pop_front();
					check_value("result.seq", result.seq, exp_item.seq);
					check_value("result.opcode", result.opcode, exp_item.opcode);
					check_value("result.c", result.c, exp_item.c);
				end
			end

			// Mirror the decoder's accept rule on this edge
			exp_reject = 1'b0;
			if (issue) begin
				seen_issue = 1'b1;
				if (is_legal(issue_cmd.opcode) && !busy) begin
					b_res = uses_imm(issue_cmd.opcode) ?
						{{13{issue_cmd.imm[18]}}, issue_cmd.imm} : issue_cmd.b;
					exp_item.seq = seq_model;
					exp_item.opcode = issue_cmd.opcode;
					exp_item.c = expected_c(issue_cmd.opcode, issue_cmd.y, b_res,
						hi_model, lo_model);
					exp_q.push_back(exp_item);
					if (issue_cmd.opcode inside {alu_pkg::op_mul, alu_pkg::op_div}) begin
						hi_model = exp_item.c[63:32];
						lo_model = exp_item.c[31:0];
					end
					seq_model = seq_model + 8'd1;
				end else begin
					exp_reject = 1'b1;
				end
			end

			if (test_end) begin
				if (exp_q.size() != 0) begin
					report_problem($sformatf("%0d results never arrived", exp_q.size()));
					exp_q.delete();
				end
				$display("test %0d %s: %0d checks, %0d errors", test_id, test_name(test_id),
					test_checks, test_errors);
				tests_run++;
				test_checks = 0;
				test_errors = 0;
			end
			if (all_done) begin
				$display("%0d tests run, %0d checks, %0d errors", tests_run, checks,
					error_count);
			end
			pending = exp_q.size();
		end
	end

endmodule

// File: sim/tb_alu_top.sv
`timescale 1ns/1ps

module tb_alu_top;
	// Run limit as a cycle budget per command issued
	localparam int MAX_CMDS = 200;
	localparam int CYCLES_PER_CMD = 40;
	localparam int TIMEOUT_CYCLES = MAX_CMDS * CYCLES_PER_CMD;
	localparam int DRAIN_LIMIT = 400;

	logic clk;
	logic rst;
	logic issue;
	alu_pkg::alu_issue_t issue_cmd;
	logic busy;
	logic reject;
	logic result_valid;
	alu_pkg::alu_result_t result;
	int test_id;
	logic test_end;
	logic all_done;
	int pending;
	int error_count;
	int cycles;
	integer seed;

	alu_top DUT (
		.clk(clk),
		.rst(rst),
		.issue(issue),
		.issue_cmd(issue_cmd),
		.busy(busy),
		.reject(reject),
		.result_valid(result_valid),
		.result(result)
	);

	alu_checker u_checker (
		.clk(clk),
		.rst(rst),
		.issue(issue),
		.issue_cmd(issue_cmd),
		.busy(busy),
		.reject(reject),
		.result_valid(result_valid),
		.result(result),
		.test_id(test_id),
		.test_end(test_end),
		.all_done(all_done),
		.pending(pending),
		.error_count(error_count)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("tests failed");
		$finish;
	end

	// Legal opcodes ordered single-cycle, immediate, HI/LO reads, then mul and div
	function automatic alu_pkg::alu_op_e legal_op(input int idx);
		case (idx)
			0: return alu_pkg::op_add;
			1: return alu_pkg::op_sub;
			2: return alu_pkg::op_and;
			3: return alu_pkg::op_or;
			4: return alu_pkg::op_neg;
			5: return alu_pkg::op_not;
			6: return alu_pkg::op_shr;
			7: return alu_pkg::op_shl;
			8: return alu_pkg::op_ror;
			9: return alu_pkg::op_rol;
			10: return alu_pkg::op_addi;
			11: return alu_pkg::op_andi;
			12: return alu_pkg::op_ori;
			13: return alu_pkg::op_load;
			14: return alu_pkg::op_loadi;
			15: return alu_pkg::op_store;
			16: return alu_pkg::op_mfhi;
			17: return alu_pkg::op_mflo;
			18: return alu_pkg::op_mul;
			default: return alu_pkg::op_div;
		endcase
	endfunction

	function automatic alu_pkg::alu_op_e illegal_op(input int idx);
		case (idx)
			0: return alu_pkg::op_branch;
			1: return alu_pkg::op_jr;
			2: return alu_pkg::op_jal;
			3: return alu_pkg::op_in;
			4: return alu_pkg::op_out;
			5: return alu_pkg::op_nop;
			6: return alu_pkg::op_halt;
			7: return alu_pkg::alu_op_e'(5'b01110);
			8: return alu_pkg::alu_op_e'(5'b11100);
			default: return alu_pkg::alu_op_e'(5'b11111);
		endcase
	endfunction

	function automatic int pick(input int span);
		return $unsigned($random(seed)) % span;
	endfunction

	// Issue one command per call and hold off while busy when asked to
	task automatic send(input alu_pkg::alu_op_e op, input logic [31:0] y,
		input logic [31:0] b, input logic [18:0] imm, input bit honor_busy);
		@(negedge clk);
		while (honor_busy && busy) begin
			issue = 1'b0;
			@(negedge clk);
		end
		issue = 1'b1;
		issue_cmd.opcode = op;
		issue_cmd.y = y;
		issue_cmd.b = b;
		issue_cmd.imm = imm;
	endtask

	task automatic run_md_pair(input logic [31:0] y, input logic [31:0] b);
		send(alu_pkg::op_mul, y, b, '0, 1'b1);
		send(alu_pkg::op_mfhi, '0, '0, '0, 1'b1);
		send(alu_pkg::op_mflo, '0, '0, '0, 1'b1);
		send(alu_pkg::op_div, y, b, '0, 1'b1);
		send(alu_pkg::op_mfhi, '0, '0, '0, 1'b1);
		send(alu_pkg::op_mflo, '0, '0, '0, 1'b1);
	endtask

	// Stop issuing, wait for the checker to see every result, then close the test
	task automatic finish_test(input int id);
		int waited;
		@(negedge clk);
		issue = 1'b0;
		waited = 0;
		while (pending != 0 && waited < DRAIN_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		@(negedge clk);
		test_id = id;
		test_end = 1'b1;
		@(negedge clk);
		test_end = 1'b0;
	endtask

	initial begin
		logic [18:0] imm;
		seed = 32'h8f9;
		rst = 1'b1;
		issue = 1'b0;
		issue_cmd = '0;
		test_id = 0;
		test_end = 1'b0;
		all_done = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		repeat (8) @(negedge clk);
		finish_test(1);

		repeat (40) send(legal_op(pick(10)), $random(seed), $random(seed), '0, 1'b1);
		finish_test(2);

		for (int i = 0; i < 24; i++) begin
			imm = $random(seed);
			// Every other immediate forced negative
			imm[18] = imm[18] | i[0];
			send(legal_op(10 + pick(6)), $random(seed), $random(seed), imm, 1'b1);
		end
		finish_test(3);

		run_md_pair(32'd7, 32'd3);
		run_md_pair(32'hffff_fff9, 32'd3);
		run_md_pair(32'd7, 32'hffff_fffd);
		run_md_pair(32'hffff_fff9, 32'hffff_fffd);
		run_md_pair(32'h8000_0000, 32'hffff_ffff);
		run_md_pair(32'h7fff_ffff, 32'h7fff_ffff);
		run_md_pair(32'd12345, 32'd0);
		run_md_pair(32'hffff_fff5, 32'd0);
		run_md_pair($random(seed), $random(seed));
		finish_test(4);

		repeat (48) send(legal_op(pick(20)), $random(seed), $random(seed), $random(seed), 1'b1);
		finish_test(5);

		for (int i = 0; i < 10; i++) begin
			send(illegal_op(i), $random(seed), $random(seed), $random(seed), 1'b1);
		end
		// Ignore busy so the queue fills and later issues bounce
		repeat (10) send(alu_pkg::op_mul, $random(seed), $random(seed), '0, 1'b0);
		send(alu_pkg::op_mfhi, '0, '0, '0, 1'b1);
		send(alu_pkg::op_mflo, '0, '0, '0, 1'b1);
		finish_test(6);

		all_done = 1'b1;
		@(negedge clk);
		all_done = 1'b0;
		@(negedge clk);
		if (error_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: list.f
verilog/alu_pkg.sv
verilog/shift_rotate.sv
verilog/mul_div_seq.sv
verilog/cmd_decode.sv
verilog/cmd_fifo.sv
verilog/alu_exec.sv
verilog/alu_top.sv
sim/alu_checker.sv
sim/tb_alu_top.sv
